// File: src/fpu_sqrt_pkg.sv
package fpu_sqrt_pkg;

    // RISC-V frm encodings; 5 to 7 fall back to round-to-nearest-even
    typedef enum logic [2:0] {
        RNE = 3'd0,
        RTZ = 3'd1,
        RDN = 3'd2,
        RUP = 3'd3,
        RMM = 3'd4
    } rounding_mode_e;

    // Operand classes as seen by the square root
    typedef enum logic [2:0] {
        CLASS_ZERO        = 3'd0,
        CLASS_NORMAL      = 3'd1,
        CLASS_INF         = 3'd2,
        CLASS_QNAN        = 3'd3,
        CLASS_SNAN        = 3'd4,
        CLASS_NEG_INVALID = 3'd5
    } fp_class_e;

    // Flag vector is NV, DZ, OF, UF, NX from msb to lsb
    localparam int FFLAGS_W = 5;
    localparam int FLAG_NV  = 4;
    localparam int FLAG_NX  = 0;

    // 24 significand bits plus the round bit
    localparam int ROOT_BITS = 25;

    // Two radicand bits per root bit
    localparam int RADICAND_W = 2 * ROOT_BITS;

    localparam int REM_W = ROOT_BITS + 2;

    localparam logic [31:0] CANONICAL_NAN = 32'h7fc0_0000;

    localparam int EXP_BIAS = 127;

endpackage

// File: src/fpu_sqrt_unpack.sv
`timescale 1ns/1ps

module fpu_sqrt_unpack (
    input  logic                                  clk,
    input  logic                                  enable,
    input  logic [31:0]                           operand,
    output logic [fpu_sqrt_pkg::RADICAND_W-1:0]   radicand,
    output logic [7:0]                            exp_half,
    output fpu_sqrt_pkg::fp_class_e               op_class,
    output logic                                  zero_sign
);
    import fpu_sqrt_pkg::*;

    logic                  sign;
    logic [7:0]            exp_field;
    logic [22:0]           frac;
    logic [4:0]            lz;
    logic [23:0]           sig;
    logic signed [9:0]     exp_unb;
    logic signed [9:0]     exp_half_wide;
    logic [RADICAND_W-1:0] rad_d;
    fp_class_e             class_d;

    assign sign      = operand[31];
    assign exp_field = operand[30:23];
    assign frac      = operand[22:0];

    // Leading zeros of the fraction, only meaningful for subnormals
    always_comb begin
        lz = '0;
        for (int i = 0; i < 23; i++) begin
            if (frac[i]) begin
                lz = 5'(22 - i);
            end
        end
    end

    always_comb begin
        if (exp_field == 8'd0) begin
            sig     = {frac, 1'b0} << lz;
            exp_unb = 10'd0 - 10'(EXP_BIAS) - {5'b0, lz};
        end else begin
            sig     = {1'b1, frac};
            exp_unb = {2'b00, exp_field} - 10'(EXP_BIAS);
        end
    end

    // Odd exponent borrows one factor of two into the significand
    assign rad_d = exp_unb[0] ? {sig, {(RADICAND_W-24){1'b0}}}
                              : {1'b0, sig, {(RADICAND_W-25){1'b0}}};

    // Arithmetic shift floors, so odd exponents land on the even one below
    assign exp_half_wide = (exp_unb >>> 1) + 10'(EXP_BIAS);

    always_comb begin
        if (exp_field == 8'hff) begin
            if (frac != '0) begin
                class_d = frac[22] ? CLASS_QNAN : CLASS_SNAN;
            end else begin
                class_d = sign ? CLASS_NEG_INVALID : CLASS_INF;
            end
        end else if (exp_field == 8'd0 && frac == '0) begin
            class_d = CLASS_ZERO;
        end else begin
            class_d = sign ? CLASS_NEG_INVALID : CLASS_NORMAL;
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            radicand  <= rad_d;
            exp_half  <= exp_half_wide[7:0];
            op_class  <= class_d;
            zero_sign <= sign;
        end
    end

endmodule

// File: src/fpu_sqrt_root_stage.sv
`timescale 1ns/1ps

module fpu_sqrt_root_stage #(
    parameter int ROOT_BITS_PER_STAGE = 5
) (
    input  logic                                  clk,
    input  logic                                  enable,
    input  logic [fpu_sqrt_pkg::RADICAND_W-1:0]   rad_in,
    input  logic [fpu_sqrt_pkg::REM_W-1:0]        rem_in,
    input  logic [fpu_sqrt_pkg::ROOT_BITS-1:0]    root_in,
    input  logic [7:0]                            exp_in,
    input  fpu_sqrt_pkg::fp_class_e               class_in,
    input  logic                                  zero_sign_in,
    output logic [fpu_sqrt_pkg::RADICAND_W-1:0]   rad_out,
    output logic [fpu_sqrt_pkg::REM_W-1:0]        rem_out,
    output logic [fpu_sqrt_pkg::ROOT_BITS-1:0]    root_out,
    output logic [7:0]                            exp_out,
    output fpu_sqrt_pkg::fp_class_e               class_out,
    output logic                                  zero_sign_out
);
    import fpu_sqrt_pkg::*;

    logic [RADICAND_W-1:0] rad_d;
    logic [REM_W-1:0]      rem_d;
    logic [ROOT_BITS-1:0]  root_d;

    // Restoring recurrence, unrolled over the digits of this stage
    always_comb begin : steps
        logic [RADICAND_W-1:0] rad;
        logic [REM_W+1:0]      rem;
        logic [REM_W+1:0]      trial;
        logic [REM_W+1:0]      subtrahend;
        logic [ROOT_BITS-1:0]  root;

        rad  = rad_in;
        rem  = {2'b00, rem_in};
        root = root_in;
        for (int i = 0; i < ROOT_BITS_PER_STAGE; i++) begin
            trial      = {rem[REM_W-1:0], rad[RADICAND_W-1 -: 2]};
            subtrahend = {2'b00, root, 2'b01};
            rad        = rad << 2;
            if (trial >= subtrahend) begin
                rem  = trial - subtrahend;
                root = {root[ROOT_BITS-2:0], 1'b1};
            end else begin
                rem  = trial;
                root = {root[ROOT_BITS-2:0], 1'b0};
            end
        end
        rad_d  = rad;
        rem_d  = rem[REM_W-1:0];
        root_d = root;
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            rad_out       <= rad_d;
            rem_out       <= rem_d;
            root_out      <= root_d;
            exp_out       <= exp_in;
            class_out     <= class_in;
            zero_sign_out <= zero_sign_in;
        end
    end

endmodule

// File: src/fpu_sqrt_round.sv
`timescale 1ns/1ps

module fpu_sqrt_round (
    input  logic                                  clk,
    input  logic                                  enable,
    input  logic [fpu_sqrt_pkg::ROOT_BITS-1:0]    root_in,
    input  logic [fpu_sqrt_pkg::REM_W-1:0]        rem_in,
    input  logic [fpu_sqrt_pkg::RADICAND_W-1:0]   rad_in,
    input  logic [7:0]                            exp_in,
    input  fpu_sqrt_pkg::fp_class_e               class_in,
    input  logic                                  zero_sign_in,
    input  fpu_sqrt_pkg::rounding_mode_e          frm,
    output logic [31:0]                           result,
    output logic [fpu_sqrt_pkg::FFLAGS_W-1:0]     fflags
);
    import fpu_sqrt_pkg::*;

    logic                round_bit;
    logic                sticky;
    logic                lsb;
    logic                round_up;
    logic [ROOT_BITS-1:0] sig_rnd;
    logic                carry;
    logic [7:0]          exp_rnd;
    logic [22:0]         frac_rnd;
    logic [31:0]         result_d;
    logic [FFLAGS_W-1:0] flags_d;

    assign round_bit = root_in[0];
    assign lsb       = root_in[1];
    assign sticky    = (rem_in != '0) || (rad_in != '0);

    // The root is always positive, so RDN truncates like RTZ
    always_comb begin
        case (frm)
            RTZ, RDN: round_up = 1'b0;
            RUP:      round_up = round_bit | sticky;
            RMM:      round_up = round_bit;
            default:  round_up = round_bit & (sticky | lsb);
        endcase
    end

    assign sig_rnd  = {1'b0, root_in[ROOT_BITS-1:1]} + ROOT_BITS'(round_up);
    assign carry    = sig_rnd[ROOT_BITS-1];
    assign exp_rnd  = exp_in + 8'(carry);
    // A carry-out leaves the fraction at zero for 1.0 of the next binade
    assign frac_rnd = sig_rnd[22:0];

    always_comb begin
        result_d = {1'b0, exp_rnd, frac_rnd};
        flags_d  = '0;
        case (class_in)
            CLASS_ZERO: begin
                result_d = {zero_sign_in, 31'b0};
            end
            CLASS_INF: begin
                result_d = {1'b0, 8'hff, 23'b0};
            end
            CLASS_QNAN: begin
                result_d = CANONICAL_NAN;
            end
            CLASS_SNAN, CLASS_NEG_INVALID: begin
                result_d         = CANONICAL_NAN;
                flags_d[FLAG_NV] = 1'b1;
            end
            default: begin
                flags_d[FLAG_NX] = round_bit | sticky;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            result <= result_d;
            fflags <= flags_d;
        end
    end

endmodule

// File: src/fpu_sqrt_lane.sv
`timescale 1ns/1ps

module fpu_sqrt_lane #(
    parameter int ROOT_BITS_PER_STAGE = 5
) (
    input  logic                                clk,
    input  logic                                enable,
    input  logic [31:0]                         dataa,
    input  fpu_sqrt_pkg::rounding_mode_e        frm,
    output logic [31:0]                         result,
    output logic [fpu_sqrt_pkg::FFLAGS_W-1:0]   fflags
);
    import fpu_sqrt_pkg::*;

    localparam int NUM_STAGES = ROOT_BITS / ROOT_BITS_PER_STAGE;

    // Index 0 is the unpack output, index NUM_STAGES feeds round
    logic [RADICAND_W-1:0] rad_c       [NUM_STAGES+1];
    logic [REM_W-1:0]      rem_c       [NUM_STAGES+1];
    logic [ROOT_BITS-1:0]  root_c      [NUM_STAGES+1];
    logic [7:0]            exp_c       [NUM_STAGES+1];
    fp_class_e             class_c     [NUM_STAGES+1];
    logic                  zero_sign_c [NUM_STAGES+1];

    fpu_sqrt_unpack unpack (
        .clk       (clk),
        .enable    (enable),
        .operand   (dataa),
        .radicand  (rad_c[0]),
        .exp_half  (exp_c[0]),
        .op_class  (class_c[0]),
        .zero_sign (zero_sign_c[0])
    );

    assign rem_c[0]  = '0;
    assign root_c[0] = '0;

    for (genvar s = 0; s < NUM_STAGES; s++) begin : g_stage
        fpu_sqrt_root_stage #(
            .ROOT_BITS_PER_STAGE (ROOT_BITS_PER_STAGE)
        ) root_stage (
            .clk           (clk),
            .enable        (enable),
            .rad_in        (rad_c[s]),
            .rem_in        (rem_c[s]),
            .root_in       (root_c[s]),
            .exp_in        (exp_c[s]),
            .class_in      (class_c[s]),
            .zero_sign_in  (zero_sign_c[s]),
            .rad_out       (rad_c[s+1]),
            .rem_out       (rem_c[s+1]),
            .root_out      (root_c[s+1]),
            .exp_out       (exp_c[s+1]),
            .class_out     (class_c[s+1]),
            .zero_sign_out (zero_sign_c[s+1])
        );
    end

    fpu_sqrt_round round (
        .clk          (clk),
        .enable       (enable),
        .root_in      (root_c[NUM_STAGES]),
        .rem_in       (rem_c[NUM_STAGES]),
        .rad_in       (rad_c[NUM_STAGES]),
        .exp_in       (exp_c[NUM_STAGES]),
        .class_in     (class_c[NUM_STAGES]),
        .zero_sign_in (zero_sign_c[NUM_STAGES]),
        .frm          (frm),
        .result       (result),
        .fflags       (fflags)
    );

endmodule

// File: src/fpu_sqrt_valid_pipe.sv
`timescale 1ns/1ps

module fpu_sqrt_valid_pipe #(
    parameter int TAGW  = 1,
    parameter int DEPTH = 7
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          enable,
    input  logic                          valid_in,
    input  logic [TAGW-1:0]               tag_in,
    input  fpu_sqrt_pkg::rounding_mode_e  frm_in,
    output logic                          valid_out,
    output logic [TAGW-1:0]               tag_out,
    output fpu_sqrt_pkg::rounding_mode_e  frm_round
);
    import fpu_sqrt_pkg::*;

    logic [DEPTH-1:0] valid_q;
    logic [TAGW-1:0]  tag_q [DEPTH];
    // frm is consumed by round, one stage before the end
    rounding_mode_e   frm_q [DEPTH-1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (enable) begin
            valid_q <= {valid_q[DEPTH-2:0], valid_in};
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            tag_q[0] <= tag_in;
            frm_q[0] <= frm_in;
            for (int i = 1; i < DEPTH; i++) begin
                tag_q[i] <= tag_q[i-1];
            end
            for (int i = 1; i < DEPTH - 1; i++) begin
                frm_q[i] <= frm_q[i-1];
            end
        end
    end

    assign valid_out = valid_q[DEPTH-1];
    assign tag_out   = tag_q[DEPTH-1];
    assign frm_round = frm_q[DEPTH-2];

endmodule

// File: src/fpu_sqrt.sv
`timescale 1ns/1ps

module fpu_sqrt #(
    parameter int NUM_LANES           = 1,
    parameter int TAGW                = 1,
    parameter int ROOT_BITS_PER_STAGE = 5
) (
    input  logic                                              clk,
    input  logic                                              rst_n,
    output logic                                              ready_in,
    input  logic                                              valid_in,
    input  logic [TAGW-1:0]                                   tag_in,
    input  logic [2:0]                                        frm,
    input  logic [NUM_LANES-1:0][31:0]                        dataa,
    output logic [NUM_LANES-1:0][31:0]                        result,
    output logic                                              has_fflags,
    output logic [NUM_LANES-1:0][fpu_sqrt_pkg::FFLAGS_W-1:0]  fflags,
    output logic [TAGW-1:0]                                   tag_out,
    input  logic                                              ready_out,
    output logic                                              valid_out
);
    import fpu_sqrt_pkg::*;

    // unpack + root stages + round
    localparam int LATENCY = 2 + ROOT_BITS / ROOT_BITS_PER_STAGE;

    logic           stall;
    logic           enable;
    rounding_mode_e frm_round;

    // Whole pipeline freezes while the head beat is not taken
    assign stall    = valid_out & ~ready_out;
    assign enable   = ~stall;
    assign ready_in = enable;

    fpu_sqrt_valid_pipe #(
        .TAGW  (TAGW),
        .DEPTH (LATENCY)
    ) valid_pipe (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (enable),
        .valid_in  (valid_in),
        .tag_in    (tag_in),
        .frm_in    (rounding_mode_e'(frm)),
        .valid_out (valid_out),
        .tag_out   (tag_out),
        .frm_round (frm_round)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        fpu_sqrt_lane #(
            .ROOT_BITS_PER_STAGE (ROOT_BITS_PER_STAGE)
        ) lane (
            .clk    (clk),
            .enable (enable),
            .dataa  (dataa[i]),
            .frm    (frm_round),
            .result (result[i]),
            .fflags (fflags[i])
        );
    end

    assign has_fflags = valid_out & (|fflags);

endmodule

// File: verification/fpu_sqrt_checker.sv
`timescale 1ns/1ps

module fpu_sqrt_checker #(
    parameter int NUM_LANES = 1,
    parameter int TAGW      = 1
) (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        ready_in,
    input logic                        ready_out,
    input logic                        valid_out,
    input logic [TAGW-1:0]             tag_out,
    input logic [NUM_LANES-1:0][31:0]  result
);
    int fails = 0;

    assert property (@(posedge clk) $rose(rst_n) |-> !valid_out)
        else begin
            $error("valid_out high right after reset");
            fails++;
        end

    // Head beat must hold while the consumer is not ready
    assert property (@(posedge clk) disable iff (!rst_n)
        (valid_out && !ready_out) |=> ($stable(valid_out) && $stable(tag_out) && $stable(result)))
        else begin
            $error("output changed during a stall");
            fails++;
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        ready_in == !(valid_out && !ready_out))
        else begin
            $error("ready_in does not follow the stall condition");
            fails++;
        end

endmodule

// File: verification/fpu_sqrt_monitor.sv
`timescale 1ns/1ps

module fpu_sqrt_monitor #(
    parameter int NUM_LANES = 1,
    parameter int TAGW      = 1,
    parameter int LATENCY   = 7
) (
    input  logic                                             clk,
    input  logic                                             rst_n,
    input  logic                                             valid_in,
    input  logic                                             ready_in,
    input  logic [TAGW-1:0]                                  tag_in,
    input  logic [2:0]                                       frm,
    input  logic [NUM_LANES-1:0][31:0]                       dataa,
    input  logic                                             valid_out,
    input  logic                                             ready_out,
    input  logic [NUM_LANES-1:0][31:0]                       result,
    input  logic [NUM_LANES-1:0][fpu_sqrt_pkg::FFLAGS_W-1:0] fflags,
    input  logic                                             has_fflags,
    input  logic [TAGW-1:0]                                  tag_out,
    output int                                               errors,
    output int                                               checks,
    output int                                               pending
);
    import fpu_sqrt_pkg::*;

    typedef struct packed {
        logic [NUM_LANES-1:0][31:0]         ops;
        logic [NUM_LANES-1:0][31:0]         res;
        logic [NUM_LANES-1:0][FFLAGS_W-1:0] flags;
        logic [TAGW-1:0]                    tag;
        int                                 accepted;
    } beat_t;

    beat_t beats [$];
    // Counts clock edges on which the pipeline advanced
    int    en_count;

    function automatic void model_sqrt(input logic [31:0] op, input logic [2:0] mode,
                                       output logic [31:0] res,
                                       output logic [FFLAGS_W-1:0] flags);
        logic [63:0] rad;
        logic [63:0] root;
        logic [63:0] cand;
        logic [23:0] sig;
        logic [24:0] kept;
        logic        rnd;
        logic        sticky;
        logic        up;
        int          e;
        int          p;
        res   = CANONICAL_NAN;
        flags = '0;
        if (op[30:23] == 8'hff && op[22:0] != '0) begin
            flags[FLAG_NV] = ~op[22];
        end else if (op[30:0] == '0) begin
            res = op;
        end else if (op[31]) begin
            flags[FLAG_NV] = 1'b1;
        end else if (op[30:23] == 8'hff) begin
            res = 32'h7f80_0000;
        end else begin
            p = 0;
            if (op[30:23] == 8'h00) begin
                for (int i = 0; i < 23; i++) begin
                    if (op[i]) p = i;
                end
                sig = {1'b0, op[22:0]} << (23 - p);
                e   = p - 149;
            end else begin
                sig = {1'b1, op[22:0]};
                e   = int'(op[30:23]) - 127;
            end
            // Scale so the root lands in 25 bits with its leading one at bit 24
            rad = {40'b0, sig} << 25;
            if (e % 2 != 0) begin
                rad = rad << 1;
                e   = e - 1;
            end
            root = '0;
            for (int b = 24; b >= 0; b--) begin
                cand = root | (64'd1 << b);
                if (cand * cand <= rad) root = cand;
            end
            rnd    = root[0];
            sticky = (root * root != rad);
            case (mode)
                3'd1, 3'd2: up = 1'b0;
                3'd3:       up = rnd | sticky;
                3'd4:       up = rnd;
                default:    up = rnd & (sticky | root[1]);
            endcase
            kept = {1'b0, root[24:1]} + 25'(up);
            if (kept[24]) begin
                res = {1'b0, 8'(e / 2 + 128), 23'b0};
            end else begin
                res = {1'b0, 8'(e / 2 + 127), kept[22:0]};
            end
            flags[FLAG_NX] = rnd | sticky;
        end
    endfunction

    task automatic record_beat;
        beat_t b;
        b.ops      = dataa;
        b.tag      = tag_in;
        b.accepted = en_count;
        for (int l = 0; l < NUM_LANES; l++) begin
            model_sqrt(dataa[l], frm, b.res[l], b.flags[l]);
        end
        beats.push_back(b);
    endtask

    task automatic check_beat;
        beat_t b;
        if (beats.size() == 0) begin
            $display("error at %0t: output beat arrived with no input outstanding", $time);
            errors++;
            return;
        end
        b = beats.pop_front();
        checks++;
        if (tag_out !== b.tag) begin
            $display("mismatch at %0t: tag_out %h, expected %h", $time, tag_out, b.tag);
            errors++;
        end
        if (en_count - b.accepted != LATENCY) begin
            $display("mismatch at %0t: tag %h took %0d enabled cycles, expected %0d",
                     $time, b.tag, en_count - b.accepted, LATENCY);
            errors++;
        end
        for (int l = 0; l < NUM_LANES; l++) begin
            if (result[l] !== b.res[l] || fflags[l] !== b.flags[l]) begin
                $display("mismatch at %0t: lane %0d sqrt(%h) gave %h flags %b, expected %h flags %b",
                         $time, l, b.ops[l], result[l], fflags[l], b.res[l], b.flags[l]);
                errors++;
            end
        end
        if (has_fflags !== (|b.flags)) begin
            $display("mismatch at %0t: has_fflags %b for tag %h", $time, has_fflags, b.tag);
            errors++;
        end
    endtask

    // Pop before push so a beat leaving and one entering on the same edge stay ordered
    always @(posedge clk) begin
        if (!rst_n) begin
            errors   = 0;
            checks   = 0;
            en_count = 0;
            beats.delete();
        end else begin
            if (valid_out && ready_out) check_beat();
            if (valid_in && ready_in) record_beat();
            if (ready_in) en_count++;
        end
        pending = beats.size();
    end

endmodule

// File: verification/fpu_sqrt_tb.sv
`timescale 1ns/1ps

module fpu_sqrt_tb;
    import fpu_sqrt_pkg::*;

    localparam int NUM_LANES      = 4;
    localparam int TAGW           = 8;
    localparam int RBPS           = 5;
    // Unpack, five root stages and round
    localparam int LATENCY        = 7;
    localparam int CLK_PERIOD     = 4;
    localparam int TOTAL_BEATS    = 200 + 60 + 100 + 100 + 300 + 1 + 16;
    localparam int TIMEOUT_CYCLES = (TOTAL_BEATS + LATENCY) * 20;

    logic                               clk = 1'b0;
    logic                               rst_n;
    logic                               valid_in;
    logic                               ready_in;
    logic [TAGW-1:0]                    tag_in;
    logic [2:0]                         frm;
    logic [NUM_LANES-1:0][31:0]         dataa;
    logic [NUM_LANES-1:0][31:0]         result;
    logic                               has_fflags;
    logic [NUM_LANES-1:0][FFLAGS_W-1:0] fflags;
    logic [TAGW-1:0]                    tag_out;
    logic                               ready_out;
    logic                               valid_out;
    logic [TAGW-1:0]                    next_tag;
    logic [31:0]                        lfsr_state = 32'h4433;
    int                                 mon_errors;
    int                                 mon_checks;
    int                                 mon_pending;
    int                                 tests;

    always #(CLK_PERIOD / 2) clk = ~clk;

    fpu_sqrt #(
        .NUM_LANES           (NUM_LANES),
        .TAGW                (TAGW),
        .ROOT_BITS_PER_STAGE (RBPS)
    ) dut (
        .clk (clk), .rst_n (rst_n), .ready_in (ready_in), .valid_in (valid_in),
        .tag_in (tag_in), .frm (frm), .dataa (dataa), .result (result),
        .has_fflags (has_fflags), .fflags (fflags), .tag_out (tag_out),
        .ready_out (ready_out), .valid_out (valid_out)
    );

    fpu_sqrt_monitor #(
        .NUM_LANES (NUM_LANES),
        .TAGW      (TAGW),
        .LATENCY   (LATENCY)
    ) monitor (
        .clk (clk), .rst_n (rst_n), .valid_in (valid_in), .ready_in (ready_in),
        .tag_in (tag_in), .frm (frm), .dataa (dataa), .valid_out (valid_out),
        .ready_out (ready_out), .result (result), .fflags (fflags),
        .has_fflags (has_fflags), .tag_out (tag_out), .errors (mon_errors),
        .checks (mon_checks), .pending (mon_pending)
    );

    bind fpu_sqrt fpu_sqrt_checker #(.NUM_LANES (NUM_LANES), .TAGW (TAGW)) checks (
        .clk (clk), .rst_n (rst_n), .ready_in (ready_in), .ready_out (ready_out),
        .valid_out (valid_out), .tag_out (tag_out), .result (result)
    );

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            bits       = {bits[30:0], fb};
        end
        return bits;
    endfunction

    function automatic logic [31:0] make_operand(input int kind);
        logic [7:0]  exp_f;
        logic [22:0] frac;
        logic [23:0] sq;
        int          pos;
        exp_f = 8'(rand_bits(8));
        frac  = 23'(rand_bits(23));
        pos   = 0;
        case (kind)
            2: begin
                case (rand_bits(4) % 10)
                    0: return 32'h0000_0000;
                    1: return 32'h8000_0000;
                    2: return 32'h7f80_0000;
                    3: return 32'hff80_0000;
                    4: return {9'h0ff, 1'b1, frac[21:0]};
                    5: return {9'h0ff, 1'b0, frac[21:1], 1'b1};
                    6: return {1'b1, 8'h01 + {1'b0, exp_f[6:0]}, frac};
                    7: return {1'b1, 8'h00, frac[22:1], 1'b1};
                    8: return {9'h1ff, 1'b1, 22'd0};
                    default: return {9'h1ff, 1'b0, frac[21:1], 1'b1};
                endcase
            end
            3: begin
                // Vary the number of leading zeros
                frac = frac >> (rand_bits(5) % 23);
                return {9'b0, frac[22:1], 1'b1};
            end
            4: begin
                sq = {12'b0, 12'(rand_bits(12)) | 12'd1};
                sq = sq * sq;
                for (int i = 0; i < 24; i++) begin
                    if (sq[i]) pos = i;
                end
                sq = sq << (23 - pos);
                return {1'b0, 8'(127 + pos), sq[22:0]};
            end
            default: begin
                if (exp_f == 8'h00) exp_f = 8'h01;
                if (exp_f == 8'hff) exp_f = 8'hfe;
                return {1'b0, exp_f, frac};
            end
        endcase
    endfunction

    task automatic send_beats(input int kind, input int count, input logic pressure);
        int   sent;
        int   k;
        logic hold;
        sent = 0;
        hold = 1'b0;
        while (sent < count) begin
            @(negedge clk);
            ready_out = pressure ? (rand_bits(2) != 0) : 1'b1;
            if (!hold) begin
                valid_in = !(pressure && rand_bits(2) == 0);
                frm      = 3'(rand_bits(3));
                tag_in   = next_tag;
                for (int l = 0; l < NUM_LANES; l++) begin
                    k        = (kind == 5) ? 1 + int'(rand_bits(2) % 3) : kind;
                    dataa[l] = make_operand(k);
                end
            end
            #1;
            hold = valid_in && !ready_in;
            if (valid_in && ready_in) begin
                sent++;
                next_tag = next_tag + 8'd1;
            end
        end
    endtask

    task automatic drain;
        @(negedge clk);
        valid_in  = 1'b0;
        ready_out = 1'b1;
        while (mon_pending != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic run_test(input string name, input int kind, input int count,
                            input logic pressure);
        int err_before;
        int chk_before;
        err_before = mon_errors + dut.checks.fails;
        chk_before = mon_checks;
        send_beats(kind, count, pressure);
        drain();
        tests++;
        $display("test %0d %s: %0d beats, %0d errors", tests, name,
                 mon_checks - chk_before, mon_errors + dut.checks.fails - err_before);
    endtask

    initial begin
        rst_n     = 1'b0;
        valid_in  = 1'b0;
        tag_in    = '0;
        frm       = '0;
        dataa     = '0;
        ready_out = 1'b1;
        next_tag  = '0;
        tests     = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        run_test("normal operands", 1, 200, 1'b0);
        run_test("special operands", 2, 60, 1'b0);
        run_test("subnormal operands", 3, 100, 1'b0);
        run_test("exact squares", 4, 100, 1'b0);
        run_test("back-pressure", 5, 300, 1'b1);
        run_test("single beat latency", 1, 1, 1'b0);
        run_test("full burst", 1, 16, 1'b0);
        $display("%0d tests, %0d beats checked, %0d errors, %0d assertion failures",
                 tests, mon_checks, mon_errors, dut.checks.fails);
        if (mon_errors == 0 && dut.checks.fails == 0 && mon_checks == TOTAL_BEATS) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: vlog.f
src/fpu_sqrt_pkg.sv
src/fpu_sqrt_unpack.sv
src/fpu_sqrt_root_stage.sv
src/fpu_sqrt_round.sv
src/fpu_sqrt_lane.sv
src/fpu_sqrt_valid_pipe.sv
src/fpu_sqrt.sv
verification/fpu_sqrt_checker.sv
verification/fpu_sqrt_monitor.sv
verification/fpu_sqrt_tb.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := fpu_sqrt_tb
FILELIST := vlog.f
OBJDIR   := obj_dir
SIMFLAGS := +verilator+error+limit+100
PASS     := TEST OK

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove build output"
	@echo "make help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP) $(SIMFLAGS))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf $(OBJDIR)
